// ==== files.f ====
+incdir+verilog
verilog/hub_pkg.sv
verilog/hub_ingress_fifo.sv
verilog/hub_downstream_gather.sv
verilog/hub_selector.sv
verilog/hub_dispatch.sv
verilog/hub_router_top.sv
verification/hub_router_sva.sv
verification/hub_router_tb.sv

// ==== verification/hub_router_sva.sv ====
module hub_router_sva import hub_pkg::*; (
    input logic       clk,
    input logic       reset,
    input logic       up_out_valid,
    input logic       up_out_ready,
    input down_mask_t down_out_valid,
    input down_mask_t down_out_ready,
    input down_mask_t down_has_odd_clusters,
    input logic       up_has_odd_clusters
);

    timeunit 1ns;
    timeprecision 1ps;

    // a word leaves only when every output can take it
    property valid_needs_all_ready;
        @(posedge clk) disable iff (reset)
            (up_out_valid || (|down_out_valid)) |-> (up_out_ready && (&down_out_ready));
    endproperty

    property quiet_in_reset;
        @(posedge clk) reset |-> (!up_out_valid && (down_out_valid == '0));
    endproperty

    // flag is the OR of the downstream flags, one cycle late
    property odd_clusters_follows;
        @(posedge clk) disable iff (reset)
            1'b1 |=> (up_has_odd_clusters == $past(|down_has_odd_clusters));
    endproperty

    assert property (valid_needs_all_ready)
        else $error("output valid while an output is not ready");
    assert property (quiet_in_reset)
        else $error("output valid during reset");
    assert property (odd_clusters_follows)
        else $error("odd clusters flag does not follow its inputs");

endmodule

bind hub_router_top hub_router_sva hub_router_sva_inst (
    .clk                   (clk),
    .reset                 (reset),
    .up_out_valid          (up_out_valid),
    .up_out_ready          (up_out_ready),
    .down_out_valid        (down_out_valid),
    .down_out_ready        (down_out_ready),
    .down_has_odd_clusters (down_has_odd_clusters),
    .up_has_odd_clusters   (up_has_odd_clusters)
);

// ==== verification/hub_router_tb.sv ====
`include "hub_defines.svh"

module hub_router_tb import hub_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int DOWN = `HUB_DOWNSTREAM_COUNT;
    // link 0 is upstream, link k+1 is downstream k
    localparam int LINKS = DOWN + 1;
    localparam int DEPTH = `HUB_FIFO_DEPTH;
    localparam int PAYLOAD_WIDTH = `HUB_MSG_WIDTH - `HUB_FPGA_ID_WIDTH - `HUB_FIFO_ID_WIDTH;
    localparam int SEQ_WIDTH = PAYLOAD_WIDTH - 4;
    localparam int MSG_PER_SOURCE = 200;
    localparam int TOTAL_MSGS = MSG_PER_SOURCE * LINKS;
    localparam int HOLD_CYCLES = 10;
    localparam int CLK_PERIOD = 10;
    localparam int WATCHDOG_CYCLES = TOTAL_MSGS * 40;
    localparam int SEED = 18;

    logic       clk;
    logic       reset;
    hub_msg_t   up_in_data;
    wire        up_in_valid;
    logic       up_in_ready;
    hub_msg_t   up_out_data;
    logic       up_out_valid;
    wire        up_out_ready;
    hub_msg_t   down_in_data [DOWN];
    wire [DOWN-1:0] down_in_valid;
    down_mask_t down_in_ready;
    hub_msg_t   down_out_data [DOWN];
    down_mask_t down_out_valid;
    wire [DOWN-1:0] down_out_ready;
    down_mask_t down_has_message_flying;
    down_mask_t down_has_odd_clusters;
    logic       up_has_message_flying;
    logic       up_has_odd_clusters;

    hub_msg_t         in_msg [LINKS];
    logic [LINKS-1:0] in_valid_all;
    logic [LINKS-1:0] out_ready_all;
    wire  [LINKS-1:0] in_ready_all = {down_in_ready, up_in_ready};
    wire  [LINKS-1:0] out_valid_all = {down_out_valid, up_out_valid};

    // expected words per source and destination pair
    logic [31:0] expect_q [LINKS*LINKS][$];
    int          offered [LINKS];
    int          sent [LINKS];
    bit          taken [LINKS];
    int          active_cycle;
    logic        stall_phase;
    logic        odd_prev;

    // occupancy of the ingress buffers and the two pipeline stages
    int          buffered [LINKS];
    bit          select_busy;
    bit          dispatch_busy;
    logic        flying_prev;

    assign up_in_data = in_msg[0];
    assign up_in_valid = in_valid_all[0];
    assign down_in_valid = in_valid_all[LINKS-1:1];
    assign up_out_ready = out_ready_all[0];
    assign down_out_ready = out_ready_all[LINKS-1:1];

    always_comb begin
        for (int k = 0; k < DOWN; k++) begin
            down_in_data[k] = in_msg[k+1];
        end
    end

    hub_router_top hub_router_top_inst (
        .clk                     (clk),
        .reset                   (reset),
        .up_in_data              (up_in_data),
        .up_in_valid             (up_in_valid),
        .up_in_ready             (up_in_ready),
        .up_out_data             (up_out_data),
        .up_out_valid            (up_out_valid),
        .up_out_ready            (up_out_ready),
        .down_in_data            (down_in_data),
        .down_in_valid           (down_in_valid),
        .down_in_ready           (down_in_ready),
        .down_out_data           (down_out_data),
        .down_out_valid          (down_out_valid),
        .down_out_ready          (down_out_ready),
        .down_has_message_flying (down_has_message_flying),
        .down_has_odd_clusters   (down_has_odd_clusters),
        .up_has_message_flying   (up_has_message_flying),
        .up_has_odd_clusters     (up_has_odd_clusters)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_value(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("error at %0d ns: %s, got %h, expected %h", $time, what, actual, expected);
            $display("Simulation failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // destination links from the routing rules, bit 0 is upstream
    function automatic logic [LINKS-1:0] expected_links(input hub_msg_t msg, input int src);
        logic [LINKS-1:0] links;
        int               id;
        links = '0;
        id = int'(msg.fpga_id);
        if (msg.fifo_id == '1) begin
            if (src == 0) begin
                links[LINKS-1:1] = '1;
            end else begin
                links[0] = 1'b1;
            end
        end else if (id >= `HUB_FIRST_DOWN_ID
                     && id < `HUB_FIRST_DOWN_ID + `HUB_IDS_PER_PORT * DOWN) begin
            links[1 + (id - `HUB_FIRST_DOWN_ID) / `HUB_IDS_PER_PORT] = 1'b1;
        end else begin
            links[0] = 1'b1;
        end
        return links;
    endfunction

    // payload holds the source link and its sequence number
    function automatic hub_msg_t make_msg(input int src, input int seq);
        hub_msg_t msg;
        msg.fpga_id = fpga_id_t'($urandom_range(15, 0));
        if ($urandom_range(3, 0) == 0) begin
            msg.fifo_id = '1;
        end else begin
            msg.fifo_id = fifo_id_t'($urandom_range(14, 0));
        end
        msg.payload = {4'(src), SEQ_WIDTH'(seq)};
        return msg;
    endfunction

    function automatic bit all_delivered();
        for (int s = 0; s < LINKS; s++) begin
            if (sent[s] != MSG_PER_SOURCE) begin
                return 1'b0;
            end
        end
        for (int q = 0; q < LINKS * LINKS; q++) begin
            if (expect_q[q].size() != 0) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    // anything offered, buffered, selected or leaving keeps the hub busy
    function automatic logic flying_expected();
        logic busy;
        busy = (|down_has_message_flying) || (|in_valid_all) || select_busy
               || ((&out_ready_all) && dispatch_busy);
        for (int s = 0; s < LINKS; s++) begin
            if (buffered[s] != 0) begin
                busy = 1'b1;
            end
        end
        return busy;
    endfunction

    // upstream first, then the lowest downstream link holding a word
    task automatic step_pipeline_model();
        int winner;
        winner = -1;
        for (int s = LINKS - 1; s >= 0; s--) begin
            if (buffered[s] != 0) begin
                winner = s;
            end
        end
        if (&out_ready_all) begin
            dispatch_busy = select_busy;
            select_busy = winner >= 0;
            if (winner >= 0) begin
                buffered[winner]--;
            end
        end
        for (int s = 0; s < LINKS; s++) begin
            if (taken[s]) begin
                buffered[s]++;
            end
        end
    endtask

    task automatic record_input(input int src, input hub_msg_t msg);
        logic [LINKS-1:0] links;
        links = expected_links(msg, src);
        for (int d = 0; d < LINKS; d++) begin
            if (links[d]) begin
                expect_q[src*LINKS+d].push_back(msg);
            end
        end
        sent[src]++;
    endtask

    task automatic check_output(input int dest, input hub_msg_t msg);
        int src;
        src = int'(msg.payload[PAYLOAD_WIDTH-1 -: 4]);
        check_value("source field of output word out of range", src < LINKS, 1);
        check_value("output word with no pending entry for its link",
                    expect_q[src*LINKS+dest].size() != 0, 1);
        check_value($sformatf("word on link %0d from link %0d", dest, src), msg,
                    expect_q[src*LINKS+dest].pop_front());
    endtask

    // stimulus, outputs stay stalled for the first cycles after reset
    always @(posedge clk) begin
        if (!reset) begin
            for (int s = 0; s < LINKS; s++) begin
                if (!in_valid_all[s] || taken[s]) begin
                    if (offered[s] < MSG_PER_SOURCE
                        && (active_cycle < HOLD_CYCLES || $urandom_range(99, 0) < 60)) begin
                        in_msg[s] <= make_msg(s, offered[s]);
                        in_valid_all[s] <= 1'b1;
                        offered[s]++;
                    end else begin
                        in_valid_all[s] <= 1'b0;
                    end
                end
            end
            for (int d = 0; d < LINKS; d++) begin
                out_ready_all[d] <= (active_cycle >= HOLD_CYCLES) && ($urandom_range(99, 0) < 70);
            end
            stall_phase <= active_cycle < HOLD_CYCLES;
            down_has_odd_clusters <= down_mask_t'($urandom);
            down_has_message_flying <= down_mask_t'($urandom);
            active_cycle <= active_cycle + 1;
        end
    end

    // monitor samples in the middle of the cycle
    always @(negedge clk) begin
        if (!reset) begin
            if (stall_phase) begin
                for (int s = 0; s < LINKS; s++) begin
                    check_value("ingress ready with outputs stalled", in_ready_all[s],
                                sent[s] < DEPTH);
                end
            end
            for (int s = 0; s < LINKS; s++) begin
                taken[s] = in_valid_all[s] && in_ready_all[s];
                if (taken[s]) begin
                    record_input(s, in_msg[s]);
                end
            end
            if (out_ready_all != '1) begin
                check_value("output valid while an output is stalled", out_valid_all, 0);
            end
            if (out_valid_all != '0) begin
                check_value("destination links of output word", out_valid_all,
                            expected_links(up_out_data,
                                           int'(up_out_data.payload[PAYLOAD_WIDTH-1 -: 4])));
            end
            for (int d = 0; d < LINKS; d++) begin
                if (out_valid_all[d]) begin
                    check_output(d, (d == 0) ? up_out_data : down_out_data[d-1]);
                end
            end
            check_value("odd clusters flag", up_has_odd_clusters, odd_prev);
            odd_prev = |down_has_odd_clusters;
            check_value("message flying flag", up_has_message_flying, flying_prev);
            flying_prev = flying_expected();
            step_pipeline_model();
        end
    end

    initial begin
        void'($urandom(SEED));
        clk = 1'b0;
        reset = 1'b1;
        in_valid_all = '0;
        out_ready_all = '0;
        down_has_odd_clusters = '0;
        down_has_message_flying = '0;
        stall_phase = 1'b1;
        active_cycle = 0;
        odd_prev = 1'b0;
        select_busy = 1'b0;
        dispatch_busy = 1'b0;
        flying_prev = 1'b0;
        for (int s = 0; s < LINKS; s++) begin
            in_msg[s] = '0;
            offered[s] = 0;
            sent[s] = 0;
            taken[s] = 1'b0;
            buffered[s] = 0;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        check_value("output valids in reset", out_valid_all, 0);
        check_value("message flying flag in reset", up_has_message_flying, 0);
        check_value("odd clusters flag in reset", up_has_odd_clusters, 0);
        @(posedge clk);
        reset <= 1'b0;
        wait (!stall_phase);
        for (int s = 0; s < LINKS; s++) begin
            check_value($sformatf("words accepted on link %0d while stalled", s), sent[s], DEPTH);
        end
        while (!all_delivered()) begin
            @(posedge clk);
        end
        // idle a while so late duplicates would still show up
        repeat (20) @(posedge clk);
        $display("Simulation completed successfully");
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: not every message was delivered within %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== verilog/hub_defines.svh ====
`ifndef HUB_DEFINES_SVH
`define HUB_DEFINES_SVH

// board id sits in the top bits, fifo id right below it
`define HUB_MSG_WIDTH        32
`define HUB_FPGA_ID_WIDTH    4
`define HUB_FIFO_ID_WIDTH    4

`define HUB_DOWNSTREAM_COUNT 4

// entries per ingress buffer
`define HUB_FIFO_DEPTH       4

// each downstream link owns a contiguous block of board ids
`define HUB_IDS_PER_PORT     3
`define HUB_FIRST_DOWN_ID    1

`endif

// ==== verilog/hub_dispatch.sv ====
`include "hub_defines.svh"

module hub_dispatch import hub_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        advance,
    input  hub_msg_t    sel_msg,
    input  logic        sel_valid,
    input  msg_source_e sel_source,
    output hub_msg_t    out_msg,
    output logic        up_out_valid,
    output down_mask_t  down_out_valid
);

    localparam int PORT_COUNT = `HUB_DOWNSTREAM_COUNT;

    route_kind_e route_kind;
    down_mask_t  table_mask;
    logic        table_to_upstream;
    down_mask_t  next_down_mask;
    logic        next_up;
    down_mask_t  down_mask_q;
    logic        up_mask_q;

    // stage controller messages carry an all ones fifo id
    always_comb begin
        if (sel_msg.fifo_id == '1) begin
            if (sel_source == source_upstream) begin
                route_kind = route_broadcast;
            end else begin
                route_kind = route_to_upstream;
            end
        end else begin
            route_kind = route_by_table;
        end
    end

    // each link owns IDS_PER_PORT consecutive board ids
    genvar port;
    generate
        for (port = 0; port < PORT_COUNT; port++) begin : g_range
            localparam fpga_id_t LOW_ID =
                fpga_id_t'(`HUB_FIRST_DOWN_ID + `HUB_IDS_PER_PORT * port);
            localparam fpga_id_t HIGH_ID =
                fpga_id_t'(`HUB_FIRST_DOWN_ID + `HUB_IDS_PER_PORT * (port + 1) - 1);

            assign table_mask[port] = (sel_msg.fpga_id >= LOW_ID)
                                      && (sel_msg.fpga_id <= HIGH_ID);
        end
    endgenerate

    // ids outside every range belong above this hub
    assign table_to_upstream = ~|table_mask;

    always_comb begin
        next_up = 1'b0;
        next_down_mask = '0;
        if (sel_valid) begin
            case (route_kind)
                route_broadcast: begin
                    next_down_mask = '1;
                end
                route_to_upstream: begin
                    next_up = 1'b1;
                end
                route_by_table: begin
                    next_down_mask = table_mask;
                    next_up = table_to_upstream;
                end
                default: begin
                    next_down_mask = '0;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            out_msg <= sel_msg;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            up_mask_q <= 1'b0;
            down_mask_q <= '0;
        end else if (advance) begin
            up_mask_q <= next_up;
            down_mask_q <= next_down_mask;
        end
    end

    // every destination fires in the same cycle, and only when all are ready
    assign up_out_valid = up_mask_q && advance;
    assign down_out_valid = down_mask_q & {PORT_COUNT{advance}};

endmodule

// ==== verilog/hub_downstream_gather.sv ====
`include "hub_defines.svh"

module hub_downstream_gather import hub_pkg::*; (
    input  down_mask_t  head_valid,
    input  hub_msg_t    head [`HUB_DOWNSTREAM_COUNT],
    input  logic        take,
    output logic        winner_valid,
    output port_index_t winner_index,
    output hub_msg_t    winner,
    output down_mask_t  pop
);

    localparam int PORT_COUNT = `HUB_DOWNSTREAM_COUNT;
    // tree is padded up to a power of two
    localparam int LEAF_COUNT = 1 << $clog2(PORT_COUNT);

    // heap numbering: node 1 is the root, node n has children 2n and 2n+1
    logic        node_valid [1:2*LEAF_COUNT-1];
    hub_msg_t    node_msg   [1:2*LEAF_COUNT-1];
    port_index_t node_index [1:2*LEAF_COUNT-1];

    genvar leaf;
    genvar node;
    genvar port;

    generate
        for (leaf = 0; leaf < LEAF_COUNT; leaf++) begin : g_leaf
            if (leaf < PORT_COUNT) begin : g_used
                assign node_valid[LEAF_COUNT+leaf] = head_valid[leaf];
                assign node_msg[LEAF_COUNT+leaf] = head[leaf];
            end else begin : g_pad
                assign node_valid[LEAF_COUNT+leaf] = 1'b0;
                assign node_msg[LEAF_COUNT+leaf] = '0;
            end
            assign node_index[LEAF_COUNT+leaf] = port_index_t'(leaf);
        end

        // left child holds the lower index and wins whenever valid
        for (node = 1; node < LEAF_COUNT; node++) begin : g_node
            assign node_valid[node] = node_valid[2*node] | node_valid[2*node+1];
            assign node_msg[node] = node_valid[2*node] ? node_msg[2*node]
                                                       : node_msg[2*node+1];
            assign node_index[node] = node_valid[2*node] ? node_index[2*node]
                                                         : node_index[2*node+1];
        end
    endgenerate

    assign winner_valid = node_valid[1];
    assign winner_index = node_index[1];
    assign winner = node_msg[1];

    // only the elected link is popped
    generate
        for (port = 0; port < PORT_COUNT; port++) begin : g_pop
            assign pop[port] = take && winner_valid
                               && (winner_index == port_index_t'(port));
        end
    endgenerate

endmodule

// ==== verilog/hub_ingress_fifo.sv ====
`include "hub_defines.svh"

module hub_ingress_fifo import hub_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  hub_msg_t in_data,
    input  logic     in_valid,
    output logic     in_ready,
    output hub_msg_t head,
    output logic     head_valid,
    input  logic     pop
);

    localparam int DEPTH = `HUB_FIFO_DEPTH;
    localparam int PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int COUNT_WIDTH = $clog2(DEPTH + 1);
    localparam logic [PTR_WIDTH-1:0] LAST_SLOT = PTR_WIDTH'(DEPTH - 1);
    localparam logic [COUNT_WIDTH-1:0] FULL_COUNT = COUNT_WIDTH'(DEPTH);

    hub_msg_t               storage [DEPTH];
    logic [PTR_WIDTH-1:0]   wr_ptr;
    logic [PTR_WIDTH-1:0]   rd_ptr;
    logic [COUNT_WIDTH-1:0] count;
    logic                   push;
    logic                   take;

    assign in_ready = count < FULL_COUNT;
    assign head_valid = count != '0;
    assign head = storage[rd_ptr];

    assign push = in_valid && in_ready;
    assign take = pop && head_valid;

    always_ff @(posedge clk) begin
        if (push) begin
            storage[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
            end
            if (take) begin
                rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
            end
            // push and pop together leave the count alone
            case ({push, take})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== verilog/hub_pkg.sv ====
`include "hub_defines.svh"

package hub_pkg;

    typedef logic [`HUB_FPGA_ID_WIDTH-1:0] fpga_id_t;
    typedef logic [`HUB_FIFO_ID_WIDTH-1:0] fifo_id_t;

    typedef struct packed {
        fpga_id_t fpga_id;
        fifo_id_t fifo_id;
        logic [`HUB_MSG_WIDTH-`HUB_FPGA_ID_WIDTH-`HUB_FIFO_ID_WIDTH-1:0] payload;
    } hub_msg_t;

    // one bit per downstream link
    typedef logic [`HUB_DOWNSTREAM_COUNT-1:0] down_mask_t;
    typedef logic [$clog2(`HUB_DOWNSTREAM_COUNT)-1:0] port_index_t;

    typedef enum logic {
        source_upstream,
        source_downstream
    } msg_source_e;

    typedef enum logic [1:0] {
        route_broadcast,
        route_to_upstream,
        route_by_table
    } route_kind_e;

endpackage

// ==== verilog/hub_router_top.sv ====
`include "hub_defines.svh"

module hub_router_top import hub_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  hub_msg_t   up_in_data,
    input  logic       up_in_valid,
    output logic       up_in_ready,
    output hub_msg_t   up_out_data,
    output logic       up_out_valid,
    input  logic       up_out_ready,
    input  hub_msg_t   down_in_data [`HUB_DOWNSTREAM_COUNT],
    input  down_mask_t down_in_valid,
    output down_mask_t down_in_ready,
    output hub_msg_t   down_out_data [`HUB_DOWNSTREAM_COUNT],
    output down_mask_t down_out_valid,
    input  down_mask_t down_out_ready,
    input  down_mask_t down_has_message_flying,
    input  down_mask_t down_has_odd_clusters,
    output logic       up_has_message_flying,
    output logic       up_has_odd_clusters
);

    localparam int PORT_COUNT = `HUB_DOWNSTREAM_COUNT;

    logic        advance;

    hub_msg_t    up_head;
    logic        up_head_valid;
    logic        up_pop;

    hub_msg_t    down_head [PORT_COUNT];
    down_mask_t  down_head_valid;
    down_mask_t  down_pop;

    logic        winner_valid;
    hub_msg_t    winner;
    logic        down_take;

    hub_msg_t    sel_msg;
    logic        sel_valid;
    msg_source_e sel_source;

    hub_msg_t    out_msg;
    logic        flying_now;

    // whole pipeline moves only when every output can take a word
    assign advance = up_out_ready && (&down_out_ready);

    hub_ingress_fifo up_fifo_inst (
        .clk        (clk),
        .reset      (reset),
        .in_data    (up_in_data),
        .in_valid   (up_in_valid),
        .in_ready   (up_in_ready),
        .head       (up_head),
        .head_valid (up_head_valid),
        .pop        (up_pop)
    );

    genvar port;
    generate
        for (port = 0; port < PORT_COUNT; port++) begin : g_down
            hub_ingress_fifo down_fifo_inst (
                .clk        (clk),
                .reset      (reset),
                .in_data    (down_in_data[port]),
                .in_valid   (down_in_valid[port]),
                .in_ready   (down_in_ready[port]),
                .head       (down_head[port]),
                .head_valid (down_head_valid[port]),
                .pop        (down_pop[port])
            );

            assign down_out_data[port] = out_msg;
        end
    endgenerate

    hub_downstream_gather gather_inst (
        .head_valid   (down_head_valid),
        .head         (down_head),
        .take         (down_take),
        .winner_valid (winner_valid),
        .winner_index (),
        .winner       (winner),
        .pop          (down_pop)
    );

    hub_selector selector_inst (
        .clk               (clk),
        .reset             (reset),
        .advance           (advance),
        .up_head           (up_head),
        .up_head_valid     (up_head_valid),
        .down_winner       (winner),
        .down_winner_valid (winner_valid),
        .up_pop            (up_pop),
        .down_take         (down_take),
        .sel_msg           (sel_msg),
        .sel_valid         (sel_valid),
        .sel_source        (sel_source)
    );

    hub_dispatch dispatch_inst (
        .clk            (clk),
        .reset          (reset),
        .advance        (advance),
        .sel_msg        (sel_msg),
        .sel_valid      (sel_valid),
        .sel_source     (sel_source),
        .out_msg        (out_msg),
        .up_out_valid   (up_out_valid),
        .down_out_valid (down_out_valid)
    );

    // one registered message feeds every output link
    assign up_out_data = out_msg;

    // anything on a link, in a buffer or in the selector counts as flying
    assign flying_now = (|down_has_message_flying)
                        || up_in_valid || (|down_in_valid)
                        || up_out_valid || (|down_out_valid)
                        || up_head_valid || (|down_head_valid)
                        || sel_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            up_has_message_flying <= 1'b0;
            up_has_odd_clusters <= 1'b0;
        end else begin
            up_has_message_flying <= flying_now;
            up_has_odd_clusters <= |down_has_odd_clusters;
        end
    end

endmodule

// ==== verilog/hub_selector.sv ====
module hub_selector import hub_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        advance,
    input  hub_msg_t    up_head,
    input  logic        up_head_valid,
    input  hub_msg_t    down_winner,
    input  logic        down_winner_valid,
    output logic        up_pop,
    output logic        down_take,
    output hub_msg_t    sel_msg,
    output logic        sel_valid,
    output msg_source_e sel_source
);

    // upstream always goes first
    assign up_pop = advance && up_head_valid;
    assign down_take = advance && !up_head_valid && down_winner_valid;

    always_ff @(posedge clk) begin
        if (advance) begin
            if (up_head_valid) begin
                sel_msg <= up_head;
            end else if (down_winner_valid) begin
                sel_msg <= down_winner;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            sel_valid <= 1'b0;
            sel_source <= source_upstream;
        end else if (advance) begin
            if (up_head_valid) begin
                sel_valid <= 1'b1;
                sel_source <= source_upstream;
            end else if (down_winner_valid) begin
                sel_valid <= 1'b1;
                sel_source <= source_downstream;
            end else begin
                // nothing waiting, slot drains
                sel_valid <= 1'b0;
            end
        end
    end

endmodule
